// ==== flist.f ====
+incdir+tests
logic/cpu_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== logic/cpu_pkg.sv ====
/* Widths, encodings and instruction field views shared by the RV32I pipeline stages.
   Modules pull these in with a wildcard import in their bodies. */
package cpu_pkg;

    localparam int XLEN     = 32;            // Data and address width
    localparam int NUM_REGS = 32;            // Integer register count, x0 included

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      byte_en_t;      // One enable per byte lane

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B                           // LUI just forwards the immediate
    } alu_op_t;

    typedef enum logic {
        WB_ALU = 1'b0,                       // Write back the ALU result
        WB_MEM = 1'b1                        // Write back the load data
    } wb_sel_t;

    // ------------------------------------------------------------------------
    // Major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef struct packed {
        logic [6:0] funct7;                  // Bit 30 selects SUB and SRA
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;                  // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                  // imm[4:0]
        logic [6:0] opcode;
    } s_type_t;

    // Same 32 bits, three ways of reading them
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } instr_u;

endpackage

// ==== logic/cpu_top.sv ====
/* Five-stage RV32I core top level, only stage instances and the wires between them.
   Instruction and data memories sit outside and answer combinationally. */
module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0      // Address of the first instruction
) (
    input  logic                clk,
    input  logic                rst_i,
    output cpu_pkg::word_t      i_mem_addr_o,
    input  cpu_pkg::word_t      i_mem_rdata_i,
    output cpu_pkg::word_t      d_mem_addr_o,
    output cpu_pkg::word_t      d_mem_wdata_o,
    output cpu_pkg::byte_en_t   d_mem_wen_o,
    input  cpu_pkg::word_t      d_mem_rdata_i
);
    import cpu_pkg::*;

    instr_u    if_instr;                         // IF/ID
    logic      if_valid;
    logic      stall;

    logic      id_valid, id_use_imm, id_reg_write, id_mem_read, id_mem_write;   // ID/EX
    alu_op_t   id_alu_op;
    reg_addr_t id_rs1, id_rs2, id_rd;
    word_t     id_rs1_data, id_rs2_data, id_imm;
    wb_sel_t   id_wb_sel;

    logic      ex_valid, ex_reg_write, ex_mem_read, ex_mem_write;   // EX/MEM
    word_t     ex_alu_result, ex_store_data;
    reg_addr_t ex_rd;
    wb_sel_t   ex_wb_sel;

    logic      wb_en;                            // MEM/WB write-back
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_i(rst_i), .stall_i(stall),
        .i_mem_addr_o(i_mem_addr_o), .i_mem_rdata_i(i_mem_rdata_i),
        .instr_o(if_instr), .instr_valid_o(if_valid)
    );

    decode_stage u_decode (
        .clk(clk), .rst_i(rst_i), .instr_i(if_instr), .instr_valid_i(if_valid),
        .stall_o(stall), .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .ex_valid_o(id_valid), .ex_alu_op_o(id_alu_op), .ex_rs1_o(id_rs1),
        .ex_rs2_o(id_rs2), .ex_rd_o(id_rd), .ex_rs1_data_o(id_rs1_data),
        .ex_rs2_data_o(id_rs2_data), .ex_imm_o(id_imm), .ex_use_imm_o(id_use_imm),
        .ex_reg_write_o(id_reg_write), .ex_mem_read_o(id_mem_read),
        .ex_mem_write_o(id_mem_write), .ex_wb_sel_o(id_wb_sel)
    );

    execute_stage u_execute (
        .clk(clk), .rst_i(rst_i),
        .ex_valid_i(id_valid), .ex_alu_op_i(id_alu_op), .ex_rs1_i(id_rs1),
        .ex_rs2_i(id_rs2), .ex_rd_i(id_rd), .ex_rs1_data_i(id_rs1_data),
        .ex_rs2_data_i(id_rs2_data), .ex_imm_i(id_imm), .ex_use_imm_i(id_use_imm),
        .ex_reg_write_i(id_reg_write), .ex_mem_read_i(id_mem_read),
        .ex_mem_write_i(id_mem_write), .ex_wb_sel_i(id_wb_sel),
        .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .mem_valid_o(ex_valid), .mem_alu_result_o(ex_alu_result),
        .mem_store_data_o(ex_store_data), .mem_rd_o(ex_rd),
        .mem_reg_write_o(ex_reg_write), .mem_mem_read_o(ex_mem_read),
        .mem_mem_write_o(ex_mem_write), .mem_wb_sel_o(ex_wb_sel)
    );

    result_stage u_result (
        .clk(clk), .rst_i(rst_i),
        .mem_valid_i(ex_valid), .mem_alu_result_i(ex_alu_result),
        .mem_store_data_i(ex_store_data), .mem_rd_i(ex_rd),
        .mem_reg_write_i(ex_reg_write), .mem_mem_read_i(ex_mem_read),
        .mem_mem_write_i(ex_mem_write), .mem_wb_sel_i(ex_wb_sel),
        .d_mem_rdata_i(d_mem_rdata_i), .d_mem_addr_o(d_mem_addr_o),
        .d_mem_wdata_o(d_mem_wdata_o), .d_mem_wen_o(d_mem_wen_o),
        .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

endmodule

// ==== logic/decode_stage.sv ====
/* Decode stage: field decode through the instruction views, immediates, load-use
   stall and the ID/EX register. Holds the register file, written from WB. */
module decode_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  cpu_pkg::instr_u    instr_i,
    input  logic               instr_valid_i,
    output logic               stall_o,
    input  logic               wb_en_i,
    input  cpu_pkg::reg_addr_t wb_rd_i,
    input  cpu_pkg::word_t     wb_data_i,
    output logic               ex_valid_o,
    output cpu_pkg::alu_op_t   ex_alu_op_o,
    output cpu_pkg::reg_addr_t ex_rs1_o,
    output cpu_pkg::reg_addr_t ex_rs2_o,
    output cpu_pkg::reg_addr_t ex_rd_o,
    output cpu_pkg::word_t     ex_rs1_data_o,
    output cpu_pkg::word_t     ex_rs2_data_o,
    output cpu_pkg::word_t     ex_imm_o,
    output logic               ex_use_imm_o,
    output logic               ex_reg_write_o,
    output logic               ex_mem_read_o,
    output logic               ex_mem_write_o,
    output cpu_pkg::wb_sel_t   ex_wb_sel_o
);
    import cpu_pkg::*;

    word_t   rs1_data, rs2_data, imm;
    alu_op_t alu_op;
    wb_sel_t wb_sel;
    logic    use_imm, reg_write, mem_read, mem_write, uses_rs1, uses_rs2;

    reg_file u_regs (
        .clk(clk), .rst_i(rst_i),
        .rs1_addr_i(instr_i.r.rs1), .rs2_addr_i(instr_i.r.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wr_en_i(wb_en_i), .wr_addr_i(wb_rd_i), .wr_data_i(wb_data_i)
    );

    function automatic alu_op_t decode_alu(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Control and immediate decode
    // ------------------------------------------------------------------------
    always_comb begin
        alu_op    = ALU_ADD;                 // Loads and stores add base and offset
        imm       = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
        wb_sel    = WB_ALU;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP: begin
                alu_op    = decode_alu(instr_i.r.funct3, instr_i.r.funct7[5]);
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_OP_IMM: begin                // Bit 30 only matters for SRAI
                alu_op    = decode_alu(instr_i.i.funct3,
                                       instr_i.i.funct3 == 3'b101 && instr_i.i.imm12[10]);
                use_imm   = 1'b1;
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                imm       = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'h000};
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                wb_sel    = WB_MEM;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                uses_rs1  = 1'b1;
            end
            OPC_STORE: begin
                imm       = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
                use_imm   = 1'b1;
                mem_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            default: ;                       // Unknown opcodes retire as NOPs
        endcase
        if (!instr_valid_i || instr_i.r.rd == '0) begin
            reg_write = 1'b0;                // x0 writes dropped here
        end
        if (!instr_valid_i) begin
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

    // Load in EX whose rd is read here, one bubble covers the memory cycle
    assign stall_o = ex_mem_read_o && ex_reg_write_o && instr_valid_i &&
                     ((uses_rs1 && instr_i.r.rs1 == ex_rd_o) ||
                      (uses_rs2 && instr_i.r.rs2 == ex_rd_o));

    // ------------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i || stall_o) begin          // Stall turns this slot into a bubble
            ex_valid_o     <= 1'b0;
            ex_reg_write_o <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else begin
            ex_valid_o     <= instr_valid_i;
            ex_reg_write_o <= reg_write;
            ex_mem_read_o  <= mem_read;
            ex_mem_write_o <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op_o   <= alu_op;
        ex_rs1_o      <= instr_i.r.rs1;
        ex_rs2_o      <= instr_i.r.rs2;
        ex_rd_o       <= instr_i.r.rd;
        ex_rs1_data_o <= rs1_data;
        ex_rs2_data_o <= rs2_data;
        ex_imm_o      <= imm;
        ex_use_imm_o  <= use_imm;
        ex_wb_sel_o   <= wb_sel;
    end

    // No write to x0 ever enters the pipe, so forwarding never sees rd zero
    a_no_x0_write : assert property (@(posedge clk) disable iff (rst_i)
        ex_reg_write_o |-> ex_rd_o != '0);

endmodule

// ==== logic/execute_stage.sv ====
/* Execute stage: operand forwarding from EX/MEM and MEM/WB, the ALU and EX/MEM.
   Load results never come from EX/MEM since decode stalls that case. */
module execute_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               ex_valid_i,
    input  cpu_pkg::alu_op_t   ex_alu_op_i,
    input  cpu_pkg::reg_addr_t ex_rs1_i,
    input  cpu_pkg::reg_addr_t ex_rs2_i,
    input  cpu_pkg::reg_addr_t ex_rd_i,
    input  cpu_pkg::word_t     ex_rs1_data_i,
    input  cpu_pkg::word_t     ex_rs2_data_i,
    input  cpu_pkg::word_t     ex_imm_i,
    input  logic               ex_use_imm_i,
    input  logic               ex_reg_write_i,
    input  logic               ex_mem_read_i,
    input  logic               ex_mem_write_i,
    input  cpu_pkg::wb_sel_t   ex_wb_sel_i,
    input  logic               wb_en_i,
    input  cpu_pkg::reg_addr_t wb_rd_i,
    input  cpu_pkg::word_t     wb_data_i,
    output logic               mem_valid_o,
    output cpu_pkg::word_t     mem_alu_result_o,
    output cpu_pkg::word_t     mem_store_data_o,
    output cpu_pkg::reg_addr_t mem_rd_o,
    output logic               mem_reg_write_o,
    output logic               mem_mem_read_o,
    output logic               mem_mem_write_o,
    output cpu_pkg::wb_sel_t   mem_wb_sel_o
);
    import cpu_pkg::*;

    word_t op_a, rs2_val, op_b, alu_result;

    // EX/MEM first, then MEM/WB, then the value read in decode
    function automatic word_t forward(reg_addr_t rs, word_t reg_val,
                                      logic mem_we, reg_addr_t mem_rd, word_t mem_val,
                                      logic wb_we, reg_addr_t wb_rd, word_t wb_val);
        if (rs == '0)                  return reg_val;     // x0 never forwarded
        if (mem_we && mem_rd == rs)    return mem_val;
        if (wb_we && wb_rd == rs)      return wb_val;
        return reg_val;
    endfunction

    assign op_a    = forward(ex_rs1_i, ex_rs1_data_i, mem_reg_write_o, mem_rd_o,
                             mem_alu_result_o, wb_en_i, wb_rd_i, wb_data_i);
    assign rs2_val = forward(ex_rs2_i, ex_rs2_data_i, mem_reg_write_o, mem_rd_o,
                             mem_alu_result_o, wb_en_i, wb_rd_i, wb_data_i);
    assign op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];      // Shift amount is 5 bits
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_result = op_b;                   // LUI
            default:    alu_result = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // EX/MEM register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid_o     <= 1'b0;
            mem_reg_write_o <= 1'b0;
            mem_mem_read_o  <= 1'b0;
            mem_mem_write_o <= 1'b0;
        end else begin
            mem_valid_o     <= ex_valid_i;
            mem_reg_write_o <= ex_reg_write_i;
            mem_mem_read_o  <= ex_mem_read_i;
            mem_mem_write_o <= ex_mem_write_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result_o <= alu_result;      // Also the data address
        mem_store_data_o <= rs2_val;         // Forwarded rs2 for SW
        mem_rd_o         <= ex_rd_i;
        mem_wb_sel_o     <= ex_wb_sel_i;
    end

    // Reset state and forwarding together keep every live operand defined
    a_operands_known : assert property (@(posedge clk) disable iff (rst_i)
        ex_valid_i |-> !$isunknown({op_a, op_b}));

endmodule

// ==== logic/fetch_unit.sv ====
/* Instruction fetch: PC register, combinational memory lookup and the IF/ID register.
   The PC only steps forward and freezes together with IF/ID on a load-use stall. */
module fetch_unit #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            stall_i,         // Hold PC and IF/ID
    output cpu_pkg::word_t  i_mem_addr_o,
    input  cpu_pkg::word_t  i_mem_rdata_i,
    output cpu_pkg::instr_u instr_o,
    output logic            instr_valid_o
);
    import cpu_pkg::*;

    word_t pc_q;

    assign i_mem_addr_o = pc_q;              // Memory answers in the same cycle

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q          <= RESET_PC;
            instr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc_q          <= pc_q + 32'd4;
            instr_valid_o <= 1'b1;           // First word arrives one cycle after reset
        end
    end

    // Fetched word, held while decode waits
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            instr_o <= i_mem_rdata_i;
        end
    end

    // Only forward steps of four, so alignment set at reset must hold forever
    a_pc_aligned : assert property (@(posedge clk) disable iff (rst_i)
        pc_q[1:0] == 2'b00);

endmodule

// ==== logic/reg_file.sv ====
/* Integer register file, two combinational read ports and one write port.
   A write in the same cycle shows through on the read ports; x0 reads as zero. */
module reg_file (
    input  logic              clk,
    input  logic              rst_i,
    input  cpu_pkg::reg_addr_t rs1_addr_i,
    input  cpu_pkg::reg_addr_t rs2_addr_i,
    output cpu_pkg::word_t    rs1_data_o,
    output cpu_pkg::word_t    rs2_data_o,
    input  logic              wr_en_i,
    input  cpu_pkg::reg_addr_t wr_addr_i,
    input  cpu_pkg::word_t    wr_data_i
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    // Architectural state starts at zero; x0 is never written
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    function automatic word_t read_port(reg_addr_t addr, logic we, reg_addr_t waddr,
                                        word_t wdata, word_t stored);
        if (addr == '0)                return '0;      // Hardwired zero
        if (we && waddr == addr)       return wdata;   // Write-through from WB
        return stored;
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i, wr_en_i, wr_addr_i, wr_data_i, regs[rs1_addr_i]);
    assign rs2_data_o = read_port(rs2_addr_i, wr_en_i, wr_addr_i, wr_data_i, regs[rs2_addr_i]);

endmodule

// ==== logic/result_stage.sv ====
/* Memory and write-back: drives the data memory from EX/MEM, registers MEM/WB and
   selects the value returned to the register file and the forwarding paths. */
module result_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               mem_valid_i,
    input  cpu_pkg::word_t     mem_alu_result_i,
    input  cpu_pkg::word_t     mem_store_data_i,
    input  cpu_pkg::reg_addr_t mem_rd_i,
    input  logic               mem_reg_write_i,
    input  logic               mem_mem_read_i,
    input  logic               mem_mem_write_i,
    input  cpu_pkg::wb_sel_t   mem_wb_sel_i,
    input  cpu_pkg::word_t     d_mem_rdata_i,
    output cpu_pkg::word_t     d_mem_addr_o,
    output cpu_pkg::word_t     d_mem_wdata_o,
    output cpu_pkg::byte_en_t  d_mem_wen_o,
    output logic               wb_en_o,
    output cpu_pkg::reg_addr_t wb_rd_o,
    output cpu_pkg::word_t     wb_data_o
);
    import cpu_pkg::*;

    word_t   alu_q, load_q;
    wb_sel_t wb_sel_q;

    assign d_mem_addr_o  = mem_alu_result_i;
    assign d_mem_wdata_o = mem_store_data_i;
    assign d_mem_wen_o   = (mem_valid_i && mem_mem_write_i) ? '1 : '0;  // Whole words only

    // MEM/WB control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_valid_i && mem_reg_write_i;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        alu_q    <= mem_alu_result_i;
        wb_rd_o  <= mem_rd_i;
        wb_sel_q <= mem_wb_sel_i;
        if (mem_mem_read_i) begin
            load_q <= d_mem_rdata_i;         // Captured only on loads
        end
    end

    assign wb_data_o = (wb_sel_q == WB_MEM) ? load_q : alu_q;

    // A store cycle writes all lanes and never overlaps a load from decode
    a_store_word : assert property (@(posedge clk) disable iff (rst_i)
        d_mem_wen_o != '0 |-> d_mem_wen_o == '1 && !mem_mem_read_i);

endmodule

// ==== tests/cpu_model.svh ====
/* Random program generator and in-order reference model for the core testbench.
   Included in the testbench module body after the memories and queues are declared. */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [31:0] lfsr_q;                         // Generator state, seeded in build_test

// Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        v      = {v[30:0], fb};
    end
    return v;
endfunction

function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic word_t encode_store(logic [11:0] imm, reg_addr_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};    // SW rs2, imm(x0)
endfunction

// ----------------------------------------------------------------------------
// Program generation
// ----------------------------------------------------------------------------
function automatic word_t random_instr();
    reg_addr_t   rd, rs1, rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [5:0]  off;
    logic [11:0] imm;
    logic [19:0] upper;
    rd    = reg_addr_t'(rand_bits(3));       // x0 to x7 keeps dependencies dense
    rs1   = reg_addr_t'(rand_bits(3));
    rs2   = reg_addr_t'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    alt   = rand_bits(1) != 0;
    off   = 6'(rand_bits(6));                // Word offset below 256
    imm   = 12'(rand_bits(12));
    upper = 20'(rand_bits(20));
    case (3'(rand_bits(3)))
        3'd0, 3'd1, 3'd2: begin
            alt = alt && (f3 == 3'd0 || f3 == 3'd5);                 // SUB or SRA
            return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
        end
        3'd3, 3'd4: begin
            if (f3 == 3'd1) begin
                imm = {7'b0000000, imm[4:0]};                       // SLLI shamt only
            end else if (f3 == 3'd5) begin
                imm = {1'b0, alt, 5'b00000, imm[4:0]};              // SRLI or SRAI
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        3'd5:    return {upper, rd, OPC_LUI};
        3'd6:    return {4'b0000, off, 2'b00, 5'd0, 3'b010, rd, OPC_LOAD};
        default: return encode_store({4'b0000, off, 2'b00}, rs2);
    endcase
endfunction

task automatic build_test();
    lfsr_q = LFSR_SEED;
    for (int a = 0; a < DMEM_WORDS; a++) begin
        dmem[a]      = rand_bits(32);
        model_mem[a] = dmem[a];
    end
    for (int k = 0; k < IMEM_WORDS; k++) begin
        imem[k] = NOP_WORD;                  // Tail of NOPs
    end
    for (int k = 0; k < RAND_LEN; k++) begin
        imem[k] = random_instr();
    end
    for (int r = 1; r < NUM_REGS; r++) begin   // Dump x1..x31 to a fixed region
        imem[RAND_LEN + r - 1] = encode_store(12'(DUMP_BASE + 4 * (r - 1)), reg_addr_t'(r));
    end
endtask

// ----------------------------------------------------------------------------
// Reference model, one instruction at a time in program order
// ----------------------------------------------------------------------------
function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];   // Sign bit fills from the left
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

task automatic run_model();
    word_t  regs [NUM_REGS];
    instr_u iw;
    word_t  a, res, addr;
    logic   wr;
    foreach (regs[r]) regs[r] = '0;
    for (int k = 0; k < PROG_LEN; k++) begin
        iw  = imem[k];
        a   = regs[iw.r.rs1];
        res = '0;
        wr  = 1'b1;
        case (iw.r.opcode)
            OPC_OP:     res = alu_model(iw.r.funct3, iw.r.funct7[5], a, regs[iw.r.rs2]);
            OPC_OP_IMM: res = alu_model(iw.i.funct3, iw.i.funct3 == 3'd5 && iw.i.imm12[10],
                                        a, sext12(iw.i.imm12));
            OPC_LUI:    res = {iw[31:12], 12'h000};
            OPC_LOAD:   res = model_mem[word_index(a + sext12(iw.i.imm12))];
            OPC_STORE: begin
                wr   = 1'b0;
                addr = a + sext12({iw.s.imm_hi, iw.s.imm_lo});
                model_mem[word_index(addr)] = regs[iw.s.rs2];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[iw.s.rs2]);
            end
            default: wr = 1'b0;
        endcase
        if (wr && iw.r.rd != 0) regs[iw.r.rd] = res;      // x0 stays zero
    end
endtask

`endif

// ==== tests/cpu_tb.sv ====
/* Testbench for the pipelined RV32I core: random program from a seeded LFSR, an
   in-order model, and a checker on every store seen at the data memory port. */
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam word_t       RESET_PC        = 32'h0000_0000;
    localparam int          RAND_LEN        = 300;
    localparam int          PROG_LEN        = RAND_LEN + NUM_REGS - 1;  // Plus register dump
    localparam int          IMEM_WORDS      = 1024;
    localparam int          DMEM_WORDS      = 128;                 // Bytes 0 to 511
    localparam word_t       DUMP_BASE       = 32'h0000_0100;
    localparam word_t       NOP_WORD        = 32'h0000_0013;       // ADDI x0, x0, 0
    localparam logic [31:0] LFSR_SEED       = 32'hcef3aac9;
    localparam int          WATCHDOG_CYCLES = 2 * PROG_LEN + 100;

    logic     clk;
    logic     rst_i;
    word_t    i_mem_addr, i_mem_rdata, imem_off;
    word_t    d_mem_addr, d_mem_wdata, d_mem_rdata;
    byte_en_t d_mem_wen;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t model_mem [DMEM_WORDS];           // Model copy of the data memory
    word_t exp_addr [$];                     // Expected stores in order
    word_t exp_data [$];
    int    stores_seen;
    int    stores_total;

    function automatic int word_index(word_t addr);
        return int'(addr[8:2]);
    endfunction

    `include "cpu_model.svh"

    cpu_top #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .rst_i(rst_i),
        .i_mem_addr_o(i_mem_addr), .i_mem_rdata_i(i_mem_rdata),
        .d_mem_addr_o(d_mem_addr), .d_mem_wdata_o(d_mem_wdata),
        .d_mem_wen_o(d_mem_wen), .d_mem_rdata_i(d_mem_rdata)
    );

    // ------------------------------------------------------------------------
    // Memories that answer in the same cycle
    // ------------------------------------------------------------------------
    assign imem_off    = i_mem_addr - RESET_PC;
    assign i_mem_rdata = imem[imem_off[11:2]];
    assign d_mem_rdata = dmem[d_mem_addr[8:2]];

    always @(posedge clk) begin
        for (int l = 0; l < 4; l++) begin
            if (d_mem_wen[l]) dmem[d_mem_addr[8:2]][8*l +: 8] <= d_mem_wdata[8*l +: 8];
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic abort_run(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_wen(string name, byte_en_t exp, byte_en_t act);
        if (act !== exp) abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    // Store monitor on the falling edge
    always @(negedge clk) begin
        if (!rst_i && d_mem_wen != '0) begin
            if (exp_addr.size() == 0) begin
                abort_run("A store appeared after every expected store had arrived");
            end else begin
                check_wen($sformatf("store %0d enables", stores_seen), '1, d_mem_wen);
                check_word($sformatf("store %0d address", stores_seen), exp_addr.pop_front(),
                           d_mem_addr);
                check_word($sformatf("store %0d data", stores_seen), exp_data.pop_front(),
                           d_mem_wdata);
                stores_seen++;
            end
        end
    end

    // Watchdog sized from the program length
    initial begin
        @(negedge rst_i);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: only %0d of %0d stores completed in %0d cycles",
                            stores_seen, stores_total, WATCHDOG_CYCLES));
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_i       = 1'b1;
        stores_seen = 0;
        build_test();
        run_model();
        stores_total = exp_addr.size();
        for (int c = 0; c < 5; c++) begin    // Reset held for five edges
            @(posedge clk);
            if (c == 4) rst_i <= 1'b0;
            @(negedge clk);
            check_wen($sformatf("reset cycle %0d enables", c), '0, d_mem_wen);
            check_word($sformatf("reset cycle %0d fetch address", c), RESET_PC, i_mem_addr);
        end
        while (stores_seen < stores_total) @(posedge clk);
        repeat (10) @(posedge clk);          // Trailing NOPs must stay quiet
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
